// File: hds_buf.sv
// Bypassing one-entry handshake buffer per lane, yields the stage load enables
`timescale 1ns/1ps
`default_nettype none

module hds_buf
#(
   parameter int ISSUE_W = 2
)
(
   input  logic               clk,
   input  logic               reset,
   input  logic               flush,
   input  logic [ISSUE_W-1:0] in_valid,
   output logic [ISSUE_W-1:0] in_ready,
   output logic [ISSUE_W-1:0] out_valid,
   input  logic [ISSUE_W-1:0] out_ready,
   output logic [ISSUE_W-1:0] load
);
   logic [ISSUE_W-1:0] occupied;

   // Empty slot, or a slot draining this cycle, takes a new item
   assign in_ready = (~occupied | out_ready) & {ISSUE_W{~flush}};
   assign load = in_valid & in_ready;
   assign out_valid = occupied;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         occupied <= '0;
      end
      else if (flush)
      begin
         occupied <= '0;
      end
      else
      begin
         // New item fills, otherwise the slot empties once taken
         occupied <= load | (occupied & ~out_ready);
      end
   end

endmodule

`default_nettype wire

// File: issue_if.sv
// Issue bundle carrying renamed micro-ops of all lanes with valid and ready
`timescale 1ns/1ps
`default_nettype none

interface issue_if
#(
   parameter int ISSUE_W = 2
);
   import ro_pkg::*;

   logic [ISSUE_W-1:0] valid;
   logic [ISSUE_W-1:0] ready;
   alu_opc_t           opc [ISSUE_W];
   pc_t                pc [ISSUE_W];
   data_t              imm [ISSUE_W];
   prf_addr_t          prs1 [ISSUE_W];
   logic [ISSUE_W-1:0] prs1_re;
   prf_addr_t          prs2 [ISSUE_W];
   logic [ISSUE_W-1:0] prs2_re;
   prf_addr_t          prd [ISSUE_W];
   logic [ISSUE_W-1:0] prd_we;
   rob_id_t            rob_id [ISSUE_W];

   modport producer (output valid, opc, pc, imm, prs1, prs1_re, prs2, prs2_re,
                     prd, prd_we, rob_id, input ready);

   modport consumer (input valid, opc, pc, imm, prs1, prs1_re, prs2, prs2_re,
                     prd, prd_we, rob_id, output ready);

endinterface

`default_nettype wire

// File: prf.sv
// Physical register file with registered read ports per lane and one write port
`timescale 1ns/1ps
`default_nettype none

module prf
#(
   parameter int ISSUE_W = 2
)
(
   input  logic              clk,
   input  logic              reset,
   prf_read_if.file          rd,
   input  logic              wb_we,
   input  ro_pkg::prf_addr_t wb_addr,
   input  ro_pkg::data_t     wb_data
);
   import ro_pkg::*;

   localparam int NREG  = 1 << PRF_AW;
   localparam int NPORT = 2 * ISSUE_W;

   data_t regs [NREG];

   // Write port, visible to reads from the next edge on
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int r = 0; r < NREG; r++)
         begin
            regs[r] <= '0;
         end
      end
      else if (wb_we)
      begin
         regs[wb_addr] <= wb_data;
      end
   end

   // Read data only moves on a strobe, so a stalled lane keeps its operands
   always_ff @(posedge clk)
   begin
      for (int p = 0; p < NPORT; p++)
      begin
         if (reset)
         begin
            rd.rdata[p] <= '0;
         end
         else if (rd.re[p])
         begin
            rd.rdata[p] <= regs[rd.raddr[p]];
         end
      end
   end

endmodule

`default_nettype wire

// File: prf_read_if.sv
// Register file read bundle, two ports per lane with strobe, address and data
`timescale 1ns/1ps
`default_nettype none

interface prf_read_if
#(
   parameter int ISSUE_W = 2
);
   import ro_pkg::*;

   // Port 2*i reads the first source of lane i, port 2*i+1 the second
   logic [2*ISSUE_W-1:0] re;
   prf_addr_t            raddr [2*ISSUE_W];
   data_t                rdata [2*ISSUE_W];

   modport stage (output re, raddr, input rdata);

   modport file (input re, raddr, output rdata);

endinterface

`default_nettype wire

// File: project.f
ro_pkg.sv
issue_if.sv
prf_read_if.sv
hds_buf.sv
prf.sv
ro_stage.sv
ro_top.sv
ro_assertions.sv
tb_ro.sv

// File: ro_assertions.sv
// Handshake and flush checker bound into the read-operand stage
`timescale 1ns/1ps
`default_nettype none

module ro_assertions
#(
   parameter int ISSUE_W = 2
)
(
   input logic                 clk,
   input logic                 reset,
   input logic                 flush,
   input logic [ISSUE_W-1:0]   in_valid,
   input logic [ISSUE_W-1:0]   in_ready,
   input logic [2*ISSUE_W-1:0] re,
   input logic [ISSUE_W-1:0]   ex_valid,
   input logic [ISSUE_W-1:0]   ex_ready,
   input ro_pkg::alu_opc_t     ex_opc [ISSUE_W],
   input ro_pkg::pc_t          ex_pc [ISSUE_W],
   input ro_pkg::data_t        ex_imm [ISSUE_W],
   input ro_pkg::prf_addr_t    ex_prd [ISSUE_W],
   input logic [ISSUE_W-1:0]   ex_prd_we,
   input ro_pkg::rob_id_t      ex_rob_id [ISSUE_W],
   input ro_pkg::data_t        ex_operand1 [ISSUE_W],
   input ro_pkg::data_t        ex_operand2 [ISSUE_W]
);
   int fail_count = 0;

   // Nothing survives a flush edge
   a_flush_clears: assert property (@(posedge clk) disable iff (reset)
      flush |=> ex_valid == '0)
   else
   begin
      $error("ex_valid high in the cycle after a flush");
      fail_count++;
   end

   for (genvar i = 0; i < ISSUE_W; i++)
   begin : g_lane
      // Stalled lane keeps its item and its operands
      a_hold: assert property (@(posedge clk) disable iff (reset)
         ex_valid[i] && !ex_ready[i] && !flush |=> ex_valid[i]
         && $stable(ex_opc[i]) && $stable(ex_pc[i]) && $stable(ex_imm[i])
         && $stable(ex_prd[i]) && $stable(ex_prd_we[i]) && $stable(ex_rob_id[i])
         && $stable(ex_operand1[i]) && $stable(ex_operand2[i]))
      else
      begin
         $error("Lane %0d output changed while stalled", i);
         fail_count++;
      end

      // A strobe belongs to an item that is taken and reaches execute next cycle
      a_strobe: assert property (@(posedge clk) disable iff (reset)
         (re[2*i] || re[2*i+1]) |-> in_valid[i] && in_ready[i] && !flush
         ##1 ex_valid[i])
      else
      begin
         $error("Lane %0d read strobe without an accepted item", i);
         fail_count++;
      end
   end

endmodule

bind ro_stage ro_assertions #(.ISSUE_W(ISSUE_W)) u_ro_assertions
(
   .clk         (clk),
   .reset       (reset),
   .flush       (flush),
   .in_valid    (iss.valid),
   .in_ready    (iss.ready),
   .re          (rd.re),
   .ex_valid    (ex_valid),
   .ex_ready    (ex_ready),
   .ex_opc      (ex_opc),
   .ex_pc       (ex_pc),
   .ex_imm      (ex_imm),
   .ex_prd      (ex_prd),
   .ex_prd_we   (ex_prd_we),
   .ex_rob_id   (ex_rob_id),
   .ex_operand1 (ex_operand1),
   .ex_operand2 (ex_operand2)
);

`default_nettype wire

// File: ro_pkg.sv
// Read-operand package with shared widths, data types and the ALU opcode enum
`default_nettype none

package ro_pkg;

   // Data path width
   localparam int DW = 32;

   // Word address, byte offset dropped
   localparam int PC_W = 30;

   // 64 physical registers
   localparam int PRF_AW = 6;

   localparam int ROB_AW = 4;

   typedef logic [DW-1:0]     data_t;
   typedef logic [PC_W-1:0]   pc_t;
   typedef logic [PRF_AW-1:0] prf_addr_t;
   typedef logic [ROB_AW-1:0] rob_id_t;

   // ALU operation codes
   typedef enum logic [2:0]
   {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4,
      ALU_SLL = 3'd5,
      ALU_SRL = 3'd6,
      ALU_SLT = 3'd7
   } alu_opc_t;

endpackage

`default_nettype wire

// File: ro_stage.sv
// Read-operand stage with lane pipeline registers, read requests and operand select
`timescale 1ns/1ps
`default_nettype none

module ro_stage
#(
   parameter int ISSUE_W = 2
)
(
   input  logic               clk,
   input  logic               reset,
   input  logic               flush,
   issue_if.consumer          iss,
   prf_read_if.stage          rd,
   input  logic [ISSUE_W-1:0] ex_ready,
   output logic [ISSUE_W-1:0] ex_valid,
   output ro_pkg::alu_opc_t   ex_opc [ISSUE_W],
   output ro_pkg::pc_t        ex_pc [ISSUE_W],
   output ro_pkg::data_t      ex_imm [ISSUE_W],
   output ro_pkg::prf_addr_t  ex_prd [ISSUE_W],
   output logic [ISSUE_W-1:0] ex_prd_we,
   output ro_pkg::rob_id_t    ex_rob_id [ISSUE_W],
   output ro_pkg::data_t      ex_operand1 [ISSUE_W],
   output ro_pkg::data_t      ex_operand2 [ISSUE_W]
);
   logic [ISSUE_W-1:0] load;
   logic [ISSUE_W-1:0] prs1_re_q;
   logic [ISSUE_W-1:0] prs2_re_q;

   hds_buf
   #(
      .ISSUE_W   (ISSUE_W)
   )
   u_buf
   (
      .clk       (clk),
      .reset     (reset),
      .flush     (flush),
      .in_valid  (iss.valid),
      .in_ready  (iss.ready),
      .out_valid (ex_valid),
      .out_ready (ex_ready),
      .load      (load)
   );

   // Stage registers, loaded only when the lane accepts
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < ISSUE_W; i++)
      begin
         if (load[i])
         begin
            ex_opc[i]    <= iss.opc[i];
            ex_pc[i]     <= iss.pc[i];
            ex_imm[i]    <= iss.imm[i];
            ex_prd[i]    <= iss.prd[i];
            ex_prd_we[i] <= iss.prd_we[i];
            ex_rob_id[i] <= iss.rob_id[i];
            prs1_re_q[i] <= iss.prs1_re[i];
            prs2_re_q[i] <= iss.prs2_re[i];
         end
      end
   end

   // Register file acts as the other half of this pipeline stage
   always_comb
   begin
      for (int i = 0; i < ISSUE_W; i++)
      begin
         rd.re[2*i]      = load[i] & iss.prs1_re[i];
         rd.re[2*i+1]    = load[i] & iss.prs2_re[i];
         rd.raddr[2*i]   = iss.prs1[i];
         rd.raddr[2*i+1] = iss.prs2[i];
      end
   end

   // Unread sources take the immediate
   always_comb
   begin
      for (int i = 0; i < ISSUE_W; i++)
      begin
         ex_operand1[i] = prs1_re_q[i] ? rd.rdata[2*i] : ex_imm[i];
         ex_operand2[i] = prs2_re_q[i] ? rd.rdata[2*i+1] : ex_imm[i];
      end
   end

endmodule

`default_nettype wire

// File: ro_top.sv
// Read-operand top level joining the stage and the register file
`timescale 1ns/1ps
`default_nettype none

module ro_top
#(
   parameter int ISSUE_W = 2
)
(
   input  logic               clk,
   input  logic               reset,
   input  logic               flush,
   // From issue queue
   input  logic [ISSUE_W-1:0] ro_valid,
   output logic [ISSUE_W-1:0] ro_ready,
   input  ro_pkg::alu_opc_t   ro_opc [ISSUE_W],
   input  ro_pkg::pc_t        ro_pc [ISSUE_W],
   input  ro_pkg::data_t      ro_imm [ISSUE_W],
   input  ro_pkg::prf_addr_t  ro_prs1 [ISSUE_W],
   input  logic [ISSUE_W-1:0] ro_prs1_re,
   input  ro_pkg::prf_addr_t  ro_prs2 [ISSUE_W],
   input  logic [ISSUE_W-1:0] ro_prs2_re,
   input  ro_pkg::prf_addr_t  ro_prd [ISSUE_W],
   input  logic [ISSUE_W-1:0] ro_prd_we,
   input  ro_pkg::rob_id_t    ro_rob_id [ISSUE_W],
   // To execute
   output logic [ISSUE_W-1:0] ex_valid,
   input  logic [ISSUE_W-1:0] ex_ready,
   output ro_pkg::alu_opc_t   ex_opc [ISSUE_W],
   output ro_pkg::pc_t        ex_pc [ISSUE_W],
   output ro_pkg::data_t      ex_imm [ISSUE_W],
   output ro_pkg::prf_addr_t  ex_prd [ISSUE_W],
   output logic [ISSUE_W-1:0] ex_prd_we,
   output ro_pkg::rob_id_t    ex_rob_id [ISSUE_W],
   output ro_pkg::data_t      ex_operand1 [ISSUE_W],
   output ro_pkg::data_t      ex_operand2 [ISSUE_W],
   // Writeback
   input  logic               wb_we,
   input  ro_pkg::prf_addr_t  wb_addr,
   input  ro_pkg::data_t      wb_data
);
   issue_if #(.ISSUE_W(ISSUE_W)) iss ();
   prf_read_if #(.ISSUE_W(ISSUE_W)) rd ();

   assign iss.valid   = ro_valid;
   assign iss.opc     = ro_opc;
   assign iss.pc      = ro_pc;
   assign iss.imm     = ro_imm;
   assign iss.prs1    = ro_prs1;
   assign iss.prs1_re = ro_prs1_re;
   assign iss.prs2    = ro_prs2;
   assign iss.prs2_re = ro_prs2_re;
   assign iss.prd     = ro_prd;
   assign iss.prd_we  = ro_prd_we;
   assign iss.rob_id  = ro_rob_id;
   assign ro_ready    = iss.ready;

   ro_stage #(.ISSUE_W(ISSUE_W)) u_ro_stage
   (
      .clk         (clk),
      .reset       (reset),
      .flush       (flush),
      .iss         (iss.consumer),
      .rd          (rd.stage),
      .ex_ready    (ex_ready),
      .ex_valid    (ex_valid),
      .ex_opc      (ex_opc),
      .ex_pc       (ex_pc),
      .ex_imm      (ex_imm),
      .ex_prd      (ex_prd),
      .ex_prd_we   (ex_prd_we),
      .ex_rob_id   (ex_rob_id),
      .ex_operand1 (ex_operand1),
      .ex_operand2 (ex_operand2)
   );

   prf #(.ISSUE_W(ISSUE_W)) u_prf
   (
      .clk     (clk),
      .reset   (reset),
      .rd      (rd.file),
      .wb_we   (wb_we),
      .wb_addr (wb_addr),
      .wb_data (wb_data)
   );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Builds the read-operand testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_ro -o tb_ro
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/tb_ro)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "Regression passed"; then
   exit 0
fi
exit 1

// File: tb_ro.sv
// Testbench for the read-operand stage with register model and lane scoreboards
`timescale 1ns/1ps
`default_nettype none

module tb_ro;
   import ro_pkg::*;

   localparam int NL = 2;
   localparam int LIMIT = 200;

   // One stimulus row, a register write or an issue on a set of lanes
   typedef struct packed
   {
      logic          is_wr;
      logic          bp;
      logic          fl;
      logic [NL-1:0] v;
      logic [NL-1:0] re1;
      logic [NL-1:0] re2;
      prf_addr_t     a1;
      prf_addr_t     a2;
      data_t         val;
   } row_t;

   // Accepted item with its predicted operands
   typedef struct packed
   {
      alu_opc_t  opc;
      pc_t       pc;
      data_t     imm;
      prf_addr_t prd;
      logic      prd_we;
      rob_id_t   rob;
      data_t     op1;
      data_t     op2;
   } item_t;

   logic          clk = 1'b0;
   logic          reset;
   logic          flush;
   logic [NL-1:0] ro_valid;
   logic [NL-1:0] ro_ready;
   alu_opc_t      ro_opc [NL];
   pc_t           ro_pc [NL];
   data_t         ro_imm [NL];
   prf_addr_t     ro_prs1 [NL];
   logic [NL-1:0] ro_prs1_re;
   prf_addr_t     ro_prs2 [NL];
   logic [NL-1:0] ro_prs2_re;
   prf_addr_t     ro_prd [NL];
   logic [NL-1:0] ro_prd_we;
   rob_id_t       ro_rob_id [NL];
   logic [NL-1:0] ex_valid;
   logic [NL-1:0] ex_ready;
   alu_opc_t      ex_opc [NL];
   pc_t           ex_pc [NL];
   data_t         ex_imm [NL];
   prf_addr_t     ex_prd [NL];
   logic [NL-1:0] ex_prd_we;
   rob_id_t       ex_rob_id [NL];
   data_t         ex_operand1 [NL];
   data_t         ex_operand2 [NL];
   logic          wb_we;
   prf_addr_t     wb_addr;
   data_t         wb_data;

   row_t          tbl [$];
   item_t         sb [NL][$];
   data_t         model [64];
   logic [15:0]   lfsr = 16'd56;
   logic          bp_mode = 1'b0;
   logic          timed_out = 1'b0;
   logic          flush_q = 1'b0;
   logic [NL-1:0] acc_q = '0;
   int            value_errs = 0;
   int            proto_errs = 0;
   int            assert_errs = 0;

   ro_top #(.ISSUE_W(NL)) ro_top_i (.*);

   always #2 clk = ~clk;

   // Galois form, taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      if (s[0])
         return (s >> 1) ^ 16'hB400;
      return s >> 1;
   endfunction

   function automatic int items_left();
      int n;
      n = 0;
      for (int i = 0; i < NL; i++)
         n += sb[i].size();
      return n;
   endfunction

   task automatic check_data(input string what, input data_t got, input data_t exp);
      if (got !== exp)
      begin
         $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
         value_errs++;
      end
   endtask

   task automatic check_opc(input string what, input alu_opc_t got, input alu_opc_t exp);
      if (got !== exp)
      begin
         $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
         value_errs++;
      end
   endtask

   task automatic check_pc(input string what, input pc_t got, input pc_t exp);
      if (got !== exp)
      begin
         $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
         value_errs++;
      end
   endtask

   task automatic check_addr(input string what, input prf_addr_t got, input prf_addr_t exp);
      if (got !== exp)
      begin
         $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
         value_errs++;
      end
   endtask

   task automatic check_rob(input string what, input rob_id_t got, input rob_id_t exp);
      if (got !== exp)
      begin
         $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
         value_errs++;
      end
   endtask

   task automatic check_mask(input string what, input logic [NL-1:0] got,
                             input logic [NL-1:0] exp);
      if (got !== exp)
      begin
         $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
         value_errs++;
      end
   endtask

   task automatic add_wr(input logic bp, input prf_addr_t a, input data_t d);
      row_t r;
      r = '0;
      r.is_wr = 1'b1;
      r.bp = bp;
      r.a1 = a;
      r.val = d;
      tbl.push_back(r);
   endtask

   task automatic add_is(input logic bp, input logic fl, input logic [NL-1:0] v,
                         input logic [NL-1:0] re1, input logic [NL-1:0] re2,
                         input prf_addr_t a1, input prf_addr_t a2, input data_t imm);
      row_t r;
      r = '{1'b0, bp, fl, v, re1, re2, a1, a2, imm};
      tbl.push_back(r);
   endtask

   // Lane fields follow from the row number and the lane
   task automatic drive_lanes(input int n, input row_t r);
      for (int i = 0; i < NL; i++)
      begin
         ro_opc[i]     = alu_opc_t'(3'(n + i));
         ro_pc[i]      = pc_t'(n * 4 + i);
         ro_imm[i]     = r.val ^ data_t'(i);
         ro_prs1[i]    = r.a1 + prf_addr_t'(i);
         ro_prs2[i]    = r.a2 + prf_addr_t'(i);
         ro_prs1_re[i] = r.re1[i];
         ro_prs2_re[i] = r.re2[i];
         ro_prd[i]     = prf_addr_t'(32 + n);
         ro_prd_we[i]  = 1'(n + i);
         ro_rob_id[i]  = rob_id_t'(n * NL + i);
      end
   endtask

   // Next rising edge plus 1 ns, with a fresh ex_ready
   task automatic next_cycle();
      @(posedge clk);
      #1;
      for (int i = 0; i < NL; i++)
      begin
         if (bp_mode)
         begin
            ex_ready[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);
         end
         else
         begin
            ex_ready[i] = 1'b1;
         end
      end
   endtask

   task automatic apply_write(input row_t r);
      wb_we = 1'b1;
      wb_addr = r.a1;
      wb_data = r.val;
      next_cycle();
      wb_we = 1'b0;
   endtask

   // Each lane holds its item until the lane takes it
   task automatic apply_issue(input int n, input row_t r);
      logic [NL-1:0] pending;
      int waited;
      drive_lanes(n, r);
      ro_valid = r.v;
      pending = r.v;
      waited = 0;
      while (pending != '0 && !timed_out)
      begin
         @(negedge clk);
         pending = pending & ~ro_ready;
         next_cycle();
         ro_valid = pending;
         waited++;
         if (waited > LIMIT)
         begin
            $display("Timeout: lanes %b never accepted their items", pending);
            timed_out = 1'b1;
         end
      end
   endtask

   task automatic apply_flush(input int n, input row_t r);
      drive_lanes(n, r);
      ro_valid = r.v;
      flush = 1'b1;
      ex_ready = '0;
      @(negedge clk);
      check_mask("ready during flush", ro_ready, '0);
      next_cycle();
      flush = 1'b0;
      ro_valid = '0;
   endtask

   task automatic drain();
      int waited;
      waited = 0;
      bp_mode = 1'b0;
      ro_valid = '0;
      while ((items_left() != 0 || ex_valid != '0) && !timed_out)
      begin
         next_cycle();
         waited++;
         if (waited > LIMIT)
         begin
            $display("Timeout: %0d accepted items never reached execute", items_left());
            timed_out = 1'b1;
         end
      end
   endtask

   // Scoreboard monitor, samples mid-cycle once the inputs have settled
   always @(negedge clk)
   begin : monitor
      item_t it;
      string tag;
      if (!reset)
      begin
         if (flush_q)
            check_mask("ex_valid after flush", ex_valid, '0);
         check_mask("ex_valid one cycle after accept", ex_valid & acc_q, acc_q);
         flush_q = flush;
         acc_q = ro_valid & ro_ready;
         for (int i = 0; i < NL; i++)
         begin
            tag = $sformatf("lane %0d", i);
            if (flush)
            begin
               sb[i].delete();
            end
            else
            begin
               if (ex_valid[i] && ex_ready[i])
               begin
                  if (sb[i].size() == 0)
                  begin
                     $display("Lane %0d delivered an item that was never accepted", i);
                     proto_errs++;
                  end
                  else
                  begin
                     it = sb[i].pop_front();
                     check_opc({tag, " opc"}, ex_opc[i], it.opc);
                     check_pc({tag, " pc"}, ex_pc[i], it.pc);
                     check_data({tag, " imm"}, ex_imm[i], it.imm);
                     check_addr({tag, " prd"}, ex_prd[i], it.prd);
                     check_mask({tag, " prd_we"}, NL'(ex_prd_we[i]), NL'(it.prd_we));
                     check_rob({tag, " rob_id"}, ex_rob_id[i], it.rob);
                     check_data({tag, " operand1"}, ex_operand1[i], it.op1);
                     check_data({tag, " operand2"}, ex_operand2[i], it.op2);
                  end
               end
               if (ro_valid[i] && ro_ready[i])
               begin
                  it.opc = ro_opc[i];
                  it.pc = ro_pc[i];
                  it.imm = ro_imm[i];
                  it.prd = ro_prd[i];
                  it.prd_we = ro_prd_we[i];
                  it.rob = ro_rob_id[i];
                  // Unread sources carry the immediate
                  it.op1 = ro_prs1_re[i] ? model[ro_prs1[i]] : ro_imm[i];
                  it.op2 = ro_prs2_re[i] ? model[ro_prs2[i]] : ro_imm[i];
                  sb[i].push_back(it);
               end
            end
         end
         // Write lands at the coming edge, after this cycle's reads
         if (wb_we)
            model[wb_addr] = wb_data;
      end
   end

   initial
   begin
      reset = 1'b1;
      flush = 1'b0;
      ro_valid = '0;
      ex_ready = '1;
      wb_we = 1'b0;
      wb_addr = '0;
      wb_data = '0;
      drive_lanes(0, '0);
      for (int r = 0; r < 64; r++)
         model[r] = '0;

      add_wr(1'b0, 6'd1, 32'h1111_0001);
      add_wr(1'b0, 6'd2, 32'h2222_0002);
      add_wr(1'b0, 6'd3, 32'h3333_0003);
      add_wr(1'b0, 6'd4, 32'h4444_0004);
      // Operand select and passthrough at full speed
      add_is(1'b0, 1'b0, 2'b11, 2'b11, 2'b00, 6'd1, 6'd3, 32'h0000_00a0);
      add_is(1'b0, 1'b0, 2'b11, 2'b00, 2'b11, 6'd1, 6'd3, 32'h0000_00b0);
      add_is(1'b0, 1'b0, 2'b11, 2'b11, 2'b11, 6'd20, 6'd40, 32'h0000_00c0);
      add_is(1'b0, 1'b0, 2'b01, 2'b01, 2'b10, 6'd2, 6'd3, 32'h0000_00d0);
      add_is(1'b0, 1'b0, 2'b10, 2'b10, 2'b10, 6'd1, 6'd2, 32'h0000_00e0);
      // Random stalls, with writes to registers under read
      add_is(1'b1, 1'b0, 2'b11, 2'b11, 2'b11, 6'd1, 6'd3, 32'h0000_0100);
      add_wr(1'b1, 6'd1, 32'hdead_0011);
      add_is(1'b1, 1'b0, 2'b11, 2'b11, 2'b01, 6'd1, 6'd3, 32'h0000_0200);
      add_wr(1'b1, 6'd4, 32'hbeef_0044);
      add_is(1'b1, 1'b0, 2'b01, 2'b01, 2'b00, 6'd3, 6'd1, 32'h0000_0300);
      add_is(1'b1, 1'b0, 2'b10, 2'b00, 2'b10, 6'd1, 6'd3, 32'h0000_0400);
      add_is(1'b1, 1'b0, 2'b11, 2'b10, 2'b11, 6'd2, 6'd4, 32'h0000_0500);
      // Flush with items in flight, then normal traffic
      add_is(1'b1, 1'b0, 2'b11, 2'b11, 2'b11, 6'd1, 6'd2, 32'h0000_0600);
      add_is(1'b1, 1'b1, 2'b11, 2'b11, 2'b11, 6'd3, 6'd4, 32'h0000_0700);
      add_is(1'b0, 1'b0, 2'b11, 2'b11, 2'b11, 6'd3, 6'd4, 32'h0000_0800);
      add_wr(1'b0, 6'd5, 32'h5555_0005);
      add_is(1'b0, 1'b0, 2'b11, 2'b01, 2'b10, 6'd5, 6'd5, 32'h0000_0900);

      repeat (16) @(posedge clk);
      #1;
      reset = 1'b0;
      for (int c = 0; c < 3; c++)
      begin
         @(negedge clk);
         check_mask("ex_valid after reset", ex_valid, '0);
         check_mask("ready after reset", ro_ready, '1);
      end
      next_cycle();

      for (int n = 0; n < tbl.size() && !timed_out; n++)
      begin
         bp_mode = tbl[n].bp;
         if (tbl[n].is_wr)
            apply_write(tbl[n]);
         else if (tbl[n].fl)
            apply_flush(n, tbl[n]);
         else
            apply_issue(n, tbl[n]);
      end
      if (!timed_out)
         drain();

      assert_errs = ro_top_i.u_ro_stage.u_ro_assertions.fail_count;
      $display("Errors: %0d value, %0d protocol, %0d assertion, timeout %0d",
               value_errs, proto_errs, assert_errs, timed_out);
      if (!timed_out && value_errs + proto_errs + assert_errs == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire
